// File: Bender.yml
package:
  name: soc_bus_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_pkg.sv
      - verilog/bus_arbiter.sv
      - verilog/bus_crossbar.sv
      - verilog/config_regs.sv
      - verilog/gpio_regs.sv
      - verilog/volume_pwm.sv
      - verilog/soc_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/soc_tb.sv

// File: list.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_crossbar.sv
verilog/config_regs.sv
verilog/gpio_regs.sv
verilog/volume_pwm.sv
verilog/soc_top.sv
verif/soc_tb.sv

// File: verif/soc_golden.txt
# name op master addr(hex) data(hex) expected(hex)
# DW: M0 writes data to addr, M1 writes expected to addr+1; OUT addr 0 oe, 1 out, 2 dac, 3 acks
ver0        RD  0 0000 0000 BAD3
ver1        RD  1 0001 0000 6032
ver2        RD  0 0002 0000 000A
ver3        RD  1 0003 0000 0001
vol_rst     RD  0 0004 0000 000F
ctl_rst     RD  1 0005 0000 0000
dac_rst     OUT 0 0002 0000 0000
oe_rst      OUT 0 0000 0000 0000
ack_rst     OUT 0 0003 0000 0000
vol_wr      WR  0 0004 0019 0000
ctl_wr      WR  1 0005 0003 0000
vol_rd_m1   RD  1 0004 0000 0019
ctl_rd_m0   RD  0 0005 0000 0003
dac_ctl     OUT 0 0002 0000 0003
ver_wr      WR  0 0000 1234 0000
ver_keep    RD  1 0000 0000 BAD3
dual_wr     DW  0 0004 0022 0002
dual_vol    RD  1 0004 0000 0022
dual_ctl    RD  0 0005 0000 0002
dual_dac    OUT 0 0002 0000 0002
gpio_dir    WR  0 4000 F0F0 0000
gpio_out    WR  1 4001 A5A5 0000
gpio_oe     OUT 0 0000 0000 F0F0
gpio_o      OUT 0 0001 0000 A5A5
gpio_rd_dir RD  1 4000 0000 F0F0
gpio_in     PIN 0 4002 3C96 3C96
unmapped    RD  0 2003 0000 0000
pwm_10      PWM 0 0004 000A 000A
pwm_40      PWM 1 0004 0028 001E

// File: verif/soc_tb.sv
// ---------------------------------------------------------------------
// Bus core testbench
// Replays the golden operation list on both host masters and checks
// read data, DAC and GPIO pins, contention and the volume PWM
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_tb;

  import soc_pkg::*;

  localparam int ACK_TIMEOUT = 20;
  localparam int PIN_TRIES   = 8;
  localparam int PERIOD      = `SOC_PWM_PERIOD;

  logic                   clk;
  logic                   rst_i;
  logic                   m0_cyc;
  logic                   m0_stb;
  logic                   m0_we;
  addr_t                  m0_adr;
  data_t                  m0_wdat;
  data_t                  m0_rdat;
  logic                   m0_ack;
  logic                   m1_cyc;
  logic                   m1_stb;
  logic                   m1_we;
  addr_t                  m1_adr;
  data_t                  m1_wdat;
  data_t                  m1_rdat;
  logic                   m1_ack;
  logic [`SOC_GPIO_W-1:0] gpio_i;
  logic [`SOC_GPIO_W-1:0] gpio_o;
  logic [`SOC_GPIO_W-1:0] gpio_oe;
  logic                   dac_volumen;
  logic                   dac_mute;
  logic                   dac_hp_nspk;

  int   errors;
  int   tests;
  int   failed_tests;
  int   m0_acks;
  int   m1_acks;
  logic timed_out;

  soc_top uut (
    .clk           (clk),
    .rst_i         (rst_i),
    .m0_cyc_i      (m0_cyc),
    .m0_stb_i      (m0_stb),
    .m0_we_i       (m0_we),
    .m0_adr_i      (m0_adr),
    .m0_dat_i      (m0_wdat),
    .m0_dat_o      (m0_rdat),
    .m0_ack_o      (m0_ack),
    .m1_cyc_i      (m1_cyc),
    .m1_stb_i      (m1_stb),
    .m1_we_i       (m1_we),
    .m1_adr_i      (m1_adr),
    .m1_dat_i      (m1_wdat),
    .m1_dat_o      (m1_rdat),
    .m1_ack_o      (m1_ack),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .gpio_oe_o     (gpio_oe),
    .dac_volumen_o (dac_volumen),
    .dac_mute_o    (dac_mute),
    .dac_hp_nspk_o (dac_hp_nspk)
  );

  always #10 clk = ~clk;

  // Ack pulses seen by each master, sampled away from the clock edge
  always @(negedge clk) begin
    if (m0_ack) begin
      m0_acks++;
    end
    if (m1_ack) begin
      m1_acks++;
    end
  end

  // ------------------------------------------------------------------
  // Bus and check tasks
  // ------------------------------------------------------------------
  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic m0_access(input logic we, input addr_t adr, input data_t wdat,
                           output data_t rdat, output logic ok);
    int cycles;
    ok = 1'b0;
    rdat = '0;
    cycles = 0;
    @(posedge clk);
    m0_cyc <= 1'b1;
    m0_stb <= 1'b1;
    m0_we <= we;
    m0_adr <= adr;
    m0_wdat <= wdat;
    while (!ok && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      if (m0_ack) begin
        ok = 1'b1;
        rdat = m0_rdat;
      end
      cycles++;
    end
    @(posedge clk);
    m0_cyc <= 1'b0;
    m0_stb <= 1'b0;
    m0_we <= 1'b0;
    if (!ok) begin
      $display("Timeout: master 0 got no ack for address %h in %0d cycles", adr, ACK_TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic m1_access(input logic we, input addr_t adr, input data_t wdat,
                           output data_t rdat, output logic ok);
    int cycles;
    ok = 1'b0;
    rdat = '0;
    cycles = 0;
    @(posedge clk);
    m1_cyc <= 1'b1;
    m1_stb <= 1'b1;
    m1_we <= we;
    m1_adr <= adr;
    m1_wdat <= wdat;
    while (!ok && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      if (m1_ack) begin
        ok = 1'b1;
        rdat = m1_rdat;
      end
      cycles++;
    end
    @(posedge clk);
    m1_cyc <= 1'b0;
    m1_stb <= 1'b0;
    m1_we <= 1'b0;
    if (!ok) begin
      $display("Timeout: master 1 got no ack for address %h in %0d cycles", adr, ACK_TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic master_access(input int master, input logic we, input addr_t adr,
                               input data_t wdat, output data_t rdat, output logic ok);
    if (master == 0) begin
      m0_access(we, adr, wdat, rdat, ok);
    end else begin
      m1_access(we, adr, wdat, rdat, ok);
    end
  endtask

  // Output group picked by the address column of an OUT line
  function automatic data_t output_view(input logic [1:0] sel);
    case (sel)
      2'd0:    return data_t'(gpio_oe);
      2'd1:    return data_t'(gpio_o);
      2'd2:    return data_t'({dac_hp_nspk, dac_mute});
      default: return data_t'({m1_ack, m0_ack});
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Golden file replay
  // ------------------------------------------------------------------
  initial begin : main
    int          fd;
    int          code;
    int          n;
    int          master;
    int          err_before;
    int          acks0;
    int          acks1;
    int          high;
    int          tries;
    string       line;
    string       name;
    string       op;
    logic [31:0] adr_v;
    logic [31:0] dat_v;
    logic [31:0] exp_v;
    data_t       rdat;
    data_t       rdat1;
    logic        ok;
    logic        ok1;

    clk = 1'b0;
    rst_i = 1'b1;
    m0_cyc = 1'b0;
    m0_stb = 1'b0;
    m0_we = 1'b0;
    m0_adr = '0;
    m0_wdat = '0;
    m1_cyc = 1'b0;
    m1_stb = 1'b0;
    m1_we = 1'b0;
    m1_adr = '0;
    m1_wdat = '0;
    gpio_i = '0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    m0_acks = 0;
    m1_acks = 0;
    timed_out = 1'b0;

    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);

    fd = $fopen("verif/soc_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file verif/soc_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = 0;
        code = $fgets(line, fd);
        if (code > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %d %h %h %h", name, op, master, adr_v, dat_v, exp_v);
        end
        if (n == 6) begin
          err_before = errors;
          case (op)
            "RD": begin
              master_access(master, 1'b0, addr_t'(adr_v), '0, rdat, ok);
              check_value(name, exp_v[15:0], rdat);
            end
            "WR": begin
              master_access(master, 1'b1, addr_t'(adr_v), dat_v[15:0], rdat, ok);
            end
            "DW": begin
              // Both masters raise cyc on the same edge
              acks0 = m0_acks;
              acks1 = m1_acks;
              fork
                m0_access(1'b1, addr_t'(adr_v), dat_v[15:0], rdat, ok);
                m1_access(1'b1, addr_t'(adr_v + 1), exp_v[15:0], rdat1, ok1);
              join
              @(negedge clk);
              check_value({name, " m0 acks"}, 16'd1, 16'(m0_acks - acks0));
              check_value({name, " m1 acks"}, 16'd1, 16'(m1_acks - acks1));
            end
            "OUT": begin
              @(negedge clk);
              check_value(name, exp_v[15:0], output_view(adr_v[1:0]));
            end
            "PIN": begin
              @(posedge clk);
              gpio_i <= dat_v[15:0];
              rdat = '0;
              tries = 0;
              // Input passes two synchronizer flops first
              while (rdat !== exp_v[15:0] && tries < PIN_TRIES && !timed_out) begin
                master_access(master, 1'b0, addr_t'(adr_v), '0, rdat, ok);
                tries++;
              end
              check_value(name, exp_v[15:0], rdat);
            end
            "PWM": begin
              master_access(master, 1'b1, addr_t'(adr_v), dat_v[15:0], rdat, ok);
              repeat (2 * PERIOD) @(posedge clk);
              high = 0;
              repeat (PERIOD) begin
                @(negedge clk);
                if (dac_volumen) begin
                  high++;
                end
              end
              check_value(name, exp_v[15:0], 16'(high));
            end
            default: begin
              $display("Unknown operation %s in test %s", op, name);
              errors++;
            end
          endcase
          tests++;
          if (errors == err_before) begin
            $display("test %-12s ok", name);
          end else begin
            failed_tests++;
            $display("test %-12s failed", name);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d tests failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/bus_arbiter.sv
// ---------------------------------------------------------------------
// Bus arbiter
// Grants the shared bus to one of the two host masters, M0 first
// from idle, handing over directly on release
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic            clk,
  input  logic            rst_i,
  input  logic            m0_cyc_i,
  input  logic            m1_cyc_i,
  output soc_pkg::grant_e grant_o
);

  import soc_pkg::*;

  grant_e grant_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      grant_q <= GRANT_NONE;
    end else begin
      case (grant_q)
        GRANT_NONE: begin
          // M0 wins a tie from idle
          if (m0_cyc_i) begin
            grant_q <= GRANT_M0;
          end else if (m1_cyc_i) begin
            grant_q <= GRANT_M1;
          end
        end
        GRANT_M0: begin
          if (!m0_cyc_i) begin
            grant_q <= m1_cyc_i ? GRANT_M1 : GRANT_NONE;
          end
        end
        GRANT_M1: begin
          if (!m1_cyc_i) begin
            grant_q <= m0_cyc_i ? GRANT_M0 : GRANT_NONE;
          end
        end
        default: grant_q <= GRANT_NONE;
      endcase
    end
  end

  assign grant_o = grant_q;

  // A grant is only ever held by a master that was requesting a cycle ago
  a_grant_m0_req: assert property (@(posedge clk) disable iff (rst_i)
    grant_q == GRANT_M0 |-> $past(m0_cyc_i));
  a_grant_m1_req: assert property (@(posedge clk) disable iff (rst_i)
    grant_q == GRANT_M1 |-> $past(m1_cyc_i));

endmodule

`default_nettype wire

// File: verilog/bus_crossbar.sv
// ---------------------------------------------------------------------
// Bus crossbar
// Routes the granted master to the target picked by the upper address
// bits and steers ack and read data back to that master
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module bus_crossbar (
  input  logic            clk,
  input  logic            rst_i,
  input  soc_pkg::grant_e grant_i,
  input  logic            m0_stb_i,
  input  logic            m0_we_i,
  input  soc_pkg::addr_t  m0_adr_i,
  input  soc_pkg::data_t  m0_dat_i,
  input  logic            m1_stb_i,
  input  logic            m1_we_i,
  input  soc_pkg::addr_t  m1_adr_i,
  input  soc_pkg::data_t  m1_dat_i,
  input  logic            cfg_ack_i,
  input  soc_pkg::data_t  cfg_dat_i,
  input  logic            gpio_ack_i,
  input  soc_pkg::data_t  gpio_dat_i,
  output soc_pkg::data_t  m0_dat_o,
  output logic            m0_ack_o,
  output soc_pkg::data_t  m1_dat_o,
  output logic            m1_ack_o,
  output logic            cfg_stb_o,
  output logic            gpio_stb_o,
  output logic            t_we_o,
  output soc_pkg::addr_t  t_adr_o,
  output soc_pkg::data_t  t_dat_o
);

  import soc_pkg::*;

  logic                 own_stb;
  logic [`SOC_SEL_W-1:0] sel;
  logic                 mapped;
  logic                 err_ack_q;
  logic                 t_ack;
  data_t                t_rdat;

  // ------------------------------------------------------------------
  // Request path
  // ------------------------------------------------------------------
  // A grant stands for an open cycle of its owner
  always_comb begin
    case (grant_i)
      GRANT_M0: own_stb = m0_stb_i;
      GRANT_M1: own_stb = m1_stb_i;
      default:  own_stb = 1'b0;
    endcase
  end

  assign t_we_o  = (grant_i == GRANT_M1) ? m1_we_i  : m0_we_i;
  assign t_adr_o = (grant_i == GRANT_M1) ? m1_adr_i : m0_adr_i;
  assign t_dat_o = (grant_i == GRANT_M1) ? m1_dat_i : m0_dat_i;

  assign sel        = t_adr_o[`SOC_ADDR_W-1 -: `SOC_SEL_W];
  assign cfg_stb_o  = own_stb && (sel == `SOC_SEL_CONFIG);
  assign gpio_stb_o = own_stb && (sel == `SOC_SEL_GPIO);
  assign mapped     = (sel == `SOC_SEL_CONFIG) || (sel == `SOC_SEL_GPIO);

  // Unmapped select acks by itself a cycle later, with zero data
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= own_stb && !mapped && !err_ack_q;
    end
  end

  // ------------------------------------------------------------------
  // Response path
  // ------------------------------------------------------------------
  assign t_ack  = cfg_ack_i || gpio_ack_i || err_ack_q;
  assign t_rdat = cfg_ack_i  ? cfg_dat_i  :
                  gpio_ack_i ? gpio_dat_i : '0;

  assign m0_ack_o = t_ack && (grant_i == GRANT_M0);
  assign m1_ack_o = t_ack && (grant_i == GRANT_M1);
  assign m0_dat_o = (grant_i == GRANT_M0) ? t_rdat : '0;
  assign m1_dat_o = (grant_i == GRANT_M1) ? t_rdat : '0;

  // The ack closes a request issued under the same grant
  a_ack_m0_owner: assert property (@(posedge clk) disable iff (rst_i)
    m0_ack_o |-> $past(grant_i) == GRANT_M0);
  a_ack_m1_owner: assert property (@(posedge clk) disable iff (rst_i)
    m1_ack_o |-> $past(grant_i) == GRANT_M1);

endmodule

`default_nettype wire

// File: verilog/config_regs.sv
// ---------------------------------------------------------------------
// Configuration register bank
// Read-only version words plus DAC volume, mute and output select
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module config_regs (
  input  logic           clk,
  input  logic           rst_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  output soc_pkg::data_t volume_o,
  output logic           mute_o,
  output logic           hp_nspk_o
);

  import soc_pkg::*;

  localparam int OFS_W = `SOC_ADDR_W - `SOC_SEL_W;
  localparam logic [63:0] VERSION = `SOC_VERSION;

  logic [OFS_W-1:0] ofs;
  logic             access;
  logic             ack_q;
  data_t            dat_q;
  data_t            rdat;
  data_t            volume_q;
  logic [1:0]       ctrl_q;

  assign ofs    = adr_i[OFS_W-1:0];
  // One access per strobe, the ack cycle itself is skipped
  assign access = stb_i && !ack_q;

  // Read mux, unused offsets give zero
  always_comb begin
    case (ofs)
      `SOC_REG_VERSION0: rdat = VERSION[63:48];
      `SOC_REG_VERSION1: rdat = VERSION[47:32];
      `SOC_REG_VERSION2: rdat = VERSION[31:16];
      `SOC_REG_VERSION3: rdat = VERSION[15:0];
      `SOC_REG_VOLUME:   rdat = volume_q;
      `SOC_REG_CONTROL:  rdat = {{(`SOC_DATA_W-2){1'b0}}, ctrl_q};
      default:           rdat = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      volume_q <= data_t'(`SOC_VOLUME_INIT);
      ctrl_q   <= 2'b00;
    end else begin
      ack_q <= access;
      // Version offsets ignore writes
      if (access && we_i && ofs == `SOC_REG_VOLUME) begin
        volume_q <= dat_i;
      end
      if (access && we_i && ofs == `SOC_REG_CONTROL) begin
        ctrl_q <= dat_i[1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= rdat;
    end
  end

  assign ack_o     = ack_q;
  assign dat_o     = dat_q;
  assign volume_o  = volume_q;
  assign mute_o    = ctrl_q[0];
  assign hp_nspk_o = ctrl_q[1];

endmodule

`default_nettype wire

// File: verilog/gpio_regs.sv
// ---------------------------------------------------------------------
// GPIO register block
// Direction and output registers, two-flop synchronized input pins
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module gpio_regs (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  soc_pkg::addr_t         adr_i,
  input  soc_pkg::data_t         dat_i,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output soc_pkg::data_t         dat_o,
  output logic                   ack_o,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o
);

  import soc_pkg::*;

  localparam int OFS_W = `SOC_ADDR_W - `SOC_SEL_W;

  logic [OFS_W-1:0]       ofs;
  logic                   access;
  logic                   ack_q;
  data_t                  dat_q;
  logic [`SOC_GPIO_W-1:0] dir_q;
  logic [`SOC_GPIO_W-1:0] out_q;
  logic [`SOC_GPIO_W-1:0] sync1_q;
  logic [`SOC_GPIO_W-1:0] sync2_q;

  assign ofs    = adr_i[OFS_W-1:0];
  assign access = stb_i && !ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      dir_q <= '0;
      out_q <= '0;
    end else begin
      ack_q <= access;
      if (access && we_i && ofs == `SOC_GPIO_DIR) begin
        dir_q <= dat_i;
      end
      if (access && we_i && ofs == `SOC_GPIO_OUT) begin
        out_q <= dat_i;
      end
    end
  end

  // Input pins are asynchronous to clk
  always_ff @(posedge clk) begin
    sync1_q <= gpio_i;
    sync2_q <= sync1_q;
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (ofs)
        `SOC_GPIO_DIR: dat_q <= dir_q;
        `SOC_GPIO_OUT: dat_q <= out_q;
        `SOC_GPIO_IN:  dat_q <= sync2_q;
        default:       dat_q <= '0;
      endcase
    end
  end

  assign ack_o     = ack_q;
  assign dat_o     = dat_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

// File: verilog/soc_consts.svh
// ---------------------------------------------------------------------
// Bus core constants
// Widths, address map, register offsets, version and PWM timing
// ---------------------------------------------------------------------
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W 15
`define SOC_DATA_W 16
`define SOC_SEL_W  3

// Target select values in the upper address bits
`define SOC_SEL_CONFIG 3'd0
`define SOC_SEL_GPIO   3'd4

// Configuration bank word offsets
`define SOC_REG_VERSION0 0
`define SOC_REG_VERSION1 1
`define SOC_REG_VERSION2 2
`define SOC_REG_VERSION3 3
`define SOC_REG_VOLUME   4
// Bit 0 mute, bit 1 headphone not speaker
`define SOC_REG_CONTROL  5

// GPIO block word offsets
`define SOC_GPIO_DIR 0
`define SOC_GPIO_OUT 1
`define SOC_GPIO_IN  2
`define SOC_GPIO_W   16

`define SOC_VERSION     64'hBAD3_6032_000A_0001
`define SOC_VOLUME_INIT 15
// 150 MHz system clock over 5 MHz PWM rate
`define SOC_PWM_PERIOD  30

`endif

// File: verilog/soc_pkg.sv
// ---------------------------------------------------------------------
// Bus core types
// Address, data and arbiter grant types shared by the bus blocks
// ---------------------------------------------------------------------
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

  // Bus payload types
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  // Current bus owner
  typedef enum logic [1:0] {
    GRANT_NONE = 2'd0,
    GRANT_M0   = 2'd1,
    GRANT_M1   = 2'd2
  } grant_e;

endpackage

`default_nettype wire

// File: verilog/soc_top.sv
// ---------------------------------------------------------------------
// Audio board bus core
// Two host masters, arbiter, crossbar, config and GPIO targets and
// the DAC volume PWM
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_top (
  input  logic                   clk,
  input  logic                   rst_i,
  // Host link 0
  input  logic                   m0_cyc_i,
  input  logic                   m0_stb_i,
  input  logic                   m0_we_i,
  input  soc_pkg::addr_t         m0_adr_i,
  input  soc_pkg::data_t         m0_dat_i,
  output soc_pkg::data_t         m0_dat_o,
  output logic                   m0_ack_o,
  // Host link 1
  input  logic                   m1_cyc_i,
  input  logic                   m1_stb_i,
  input  logic                   m1_we_i,
  input  soc_pkg::addr_t         m1_adr_i,
  input  soc_pkg::data_t         m1_dat_i,
  output soc_pkg::data_t         m1_dat_o,
  output logic                   m1_ack_o,
  // GPIO pad, split
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  // DAC control
  output logic                   dac_volumen_o,
  output logic                   dac_mute_o,
  output logic                   dac_hp_nspk_o
);

  import soc_pkg::*;

  grant_e grant;
  logic   cfg_stb;
  logic   gpio_stb;
  logic   t_we;
  addr_t  t_adr;
  data_t  t_dat;
  logic   cfg_ack;
  data_t  cfg_dat;
  logic   gpio_ack;
  data_t  gpio_dat;
  data_t  volume;

  // ------------------------------------------------------------------
  // Interconnect
  // ------------------------------------------------------------------
  bus_arbiter u_arbiter (
    .clk      (clk),
    .rst_i    (rst_i),
    .m0_cyc_i (m0_cyc_i),
    .m1_cyc_i (m1_cyc_i),
    .grant_o  (grant)
  );

  bus_crossbar u_crossbar (
    .clk        (clk),
    .rst_i      (rst_i),
    .grant_i    (grant),
    .m0_stb_i   (m0_stb_i),
    .m0_we_i    (m0_we_i),
    .m0_adr_i   (m0_adr_i),
    .m0_dat_i   (m0_dat_i),
    .m1_stb_i   (m1_stb_i),
    .m1_we_i    (m1_we_i),
    .m1_adr_i   (m1_adr_i),
    .m1_dat_i   (m1_dat_i),
    .cfg_ack_i  (cfg_ack),
    .cfg_dat_i  (cfg_dat),
    .gpio_ack_i (gpio_ack),
    .gpio_dat_i (gpio_dat),
    .m0_dat_o   (m0_dat_o),
    .m0_ack_o   (m0_ack_o),
    .m1_dat_o   (m1_dat_o),
    .m1_ack_o   (m1_ack_o),
    .cfg_stb_o  (cfg_stb),
    .gpio_stb_o (gpio_stb),
    .t_we_o     (t_we),
    .t_adr_o    (t_adr),
    .t_dat_o    (t_dat)
  );

  // ------------------------------------------------------------------
  // Targets
  // ------------------------------------------------------------------
  config_regs u_config (
    .clk       (clk),
    .rst_i     (rst_i),
    .stb_i     (cfg_stb),
    .we_i      (t_we),
    .adr_i     (t_adr),
    .dat_i     (t_dat),
    .dat_o     (cfg_dat),
    .ack_o     (cfg_ack),
    .volume_o  (volume),
    .mute_o    (dac_mute_o),
    .hp_nspk_o (dac_hp_nspk_o)
  );

  gpio_regs u_gpio (
    .clk       (clk),
    .rst_i     (rst_i),
    .stb_i     (gpio_stb),
    .we_i      (t_we),
    .adr_i     (t_adr),
    .dat_i     (t_dat),
    .gpio_i    (gpio_i),
    .dat_o     (gpio_dat),
    .ack_o     (gpio_ack),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  volume_pwm u_volume_pwm (
    .clk      (clk),
    .rst_i    (rst_i),
    .volume_i (volume),
    .pwm_o    (dac_volumen_o)
  );

endmodule

`default_nettype wire

// File: verilog/volume_pwm.sv
// ---------------------------------------------------------------------
// DAC volume PWM
// High while the period counter is below the volume setting
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module volume_pwm (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic [`SOC_DATA_W-1:0] volume_i,
  output logic                   pwm_o
);

  localparam int PERIOD = `SOC_PWM_PERIOD;
  localparam int CNT_W  = $clog2(PERIOD);
  localparam int DATA_W = `SOC_DATA_W;

  logic [CNT_W-1:0] count_q;
  logic             pwm_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      if (count_q == CNT_W'(PERIOD - 1)) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
      // Volume above the period keeps the output high
      pwm_q <= DATA_W'(count_q) < volume_i;
    end
  end

  assign pwm_o = pwm_q;

  a_count_range: assert property (@(posedge clk) disable iff (rst_i)
    count_q < CNT_W'(PERIOD));

endmodule

`default_nettype wire
